//--- all.f
+incdir+include
logic/ascon_pkg.sv
logic/ascon_ctrl_if.sv
logic/ascon_round.sv
logic/ascon_absorb.sv
logic/ascon_state.sv
logic/ascon_ctrl.sv
logic/ascon_top.sv
tests/tb_ascon.sv

//--- tests/tb_ascon.sv
// ##########################################################################
// testbench of the Ascon-128a top that checks random messages against a model
// ##########################################################################
`timescale 1ns/1ps
`include "ascon_cfg.svh"

module tb_ascon;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_MSG    = 21;   // empty message plus 20 random ones
    localparam int MAX_BLK    = 5;
    localparam int WATCHDOG_CYCLES = (40 * MAX_BLK + 40) * NUM_MSG;

    // sbox as a table with x0 as the msb of the column
    localparam logic [4:0] SBOX [0:31] = '{
        5'h04, 5'h0b, 5'h1f, 5'h14, 5'h1a, 5'h15, 5'h09, 5'h02,
        5'h1b, 5'h05, 5'h08, 5'h12, 5'h1d, 5'h03, 5'h06, 5'h1c,
        5'h1e, 5'h13, 5'h07, 5'h0e, 5'h00, 5'h0d, 5'h11, 5'h18,
        5'h10, 5'h0c, 5'h01, 5'h19, 5'h16, 5'h0a, 5'h0f, 5'h17};
    localparam logic [7:0] RC [0:11] = '{
        8'hf0, 8'he1, 8'hd2, 8'hc3, 8'hb4, 8'ha5,
        8'h96, 8'h87, 8'h78, 8'h69, 8'h5a, 8'h4b};

    logic              clk;
    logic              i_rst_n;
    logic              i_start;
    ascon_pkg::block_t i_key;
    ascon_pkg::block_t i_nonce;
    ascon_pkg::block_t i_data;
    logic              i_valid_data;
    logic              i_last_block;
    logic [4:0]        i_valid_bytes;
    logic              o_ready_for_data;
    logic              o_ciphertext_valid;
    ascon_pkg::block_t o_ciphertext;
    logic              o_tag_valid;
    ascon_pkg::block_t o_tag;

    logic [31:0]       lcg_state = 32'hcb81;
    int                errors = 0;
    int                checks = 0;
    int                msg_no = 0;
    int                cur_nblk = 0;
    int                ct_cnt = 0;    // ciphertext strobes seen in this message
    int                tag_cnt = 0;
    ascon_pkg::block_t msg_blk  [0:MAX_BLK-1];
    ascon_pkg::block_t exp_ct   [0:MAX_BLK-1];
    ascon_pkg::block_t exp_mask [0:MAX_BLK-1]; // valid ciphertext bytes
    ascon_pkg::block_t exp_tag;

    ascon_top dut (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_start            (i_start),
        .i_key              (i_key),
        .i_nonce            (i_nonce),
        .i_data             (i_data),
        .i_valid_data       (i_valid_data),
        .i_last_block       (i_last_block),
        .i_valid_bytes      (i_valid_bytes),
        .o_ready_for_data   (o_ready_for_data),
        .o_ciphertext_valid (o_ciphertext_valid),
        .o_ciphertext       (o_ciphertext),
        .o_tag_valid        (o_tag_valid),
        .o_tag              (o_tag)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic ascon_pkg::block_t rand_block();
        ascon_pkg::block_t b;
        for (int i = 0; i < 4; i++) begin
            b[32*i +: 32] = next_rand();
        end
        return b;
    endfunction

    function automatic ascon_pkg::word_t rotate_right(input ascon_pkg::word_t x, input int n);
        logic [127:0] d;
        d = {x, x} >> n;
        return d[63:0];
    endfunction

    // constant, table sbox per bit column, then diffusion
    function automatic ascon_pkg::state_t model_round(input ascon_pkg::state_t s, input int r);
        ascon_pkg::state_t t;
        logic [4:0]        col;
        s[2][7:0] = s[2][7:0] ^ RC[r];
        for (int b = 0; b < 64; b++) begin
            col = SBOX[{s[0][b], s[1][b], s[2][b], s[3][b], s[4][b]}];
            {t[0][b], t[1][b], t[2][b], t[3][b], t[4][b]} = col;
        end
        s[0] = t[0] ^ rotate_right(t[0], 19) ^ rotate_right(t[0], 28);
        s[1] = t[1] ^ rotate_right(t[1], 61) ^ rotate_right(t[1], 39);
        s[2] = t[2] ^ rotate_right(t[2], 1) ^ rotate_right(t[2], 6);
        s[3] = t[3] ^ rotate_right(t[3], 10) ^ rotate_right(t[3], 17);
        s[4] = t[4] ^ rotate_right(t[4], 7) ^ rotate_right(t[4], 41);
        return s;
    endfunction

    // last n rounds of the 12-round schedule
    function automatic ascon_pkg::state_t permute(input ascon_pkg::state_t s, input int n);
        for (int r = 12 - n; r < 12; r++) begin
            s = model_round(s, r);
        end
        return s;
    endfunction

    // reads msg_blk, fills exp_ct, returns the tag
    function automatic ascon_pkg::block_t ref_encrypt(input ascon_pkg::block_t key,
                                                      input ascon_pkg::block_t nonce,
                                                      input int nblk, input int last_len);
        ascon_pkg::state_t s;
        ascon_pkg::block_t blk;
        ascon_pkg::block_t keep;
        s = {`ASCON_IV, key, nonce};
        s = permute(s, `ASCON_PA_ROUNDS);
        s[3] = s[3] ^ key[127:64];
        s[4] = s[4] ^ key[63:0] ^ 64'd1;  // empty ad leaves only the domain bit
        for (int i = 0; i < nblk; i++) begin
            blk = msg_blk[i];
            if (i == nblk - 1) begin
                keep = ~({128{1'b1}} >> (8 * last_len));
                blk  = (blk & keep) | (128'h80 << (8 * (15 - last_len)));
            end
            s[0] = s[0] ^ blk[127:64];
            s[1] = s[1] ^ blk[63:0];
            exp_ct[i] = {s[0], s[1]};
            if (i != nblk - 1) s = permute(s, `ASCON_PB_ROUNDS);
        end
        s[2] = s[2] ^ key[127:64];
        s[3] = s[3] ^ key[63:0];
        s = permute(s, `ASCON_PA_ROUNDS);
        return {s[3] ^ key[127:64], s[4] ^ key[63:0]};
    endfunction

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // called at a negedge and counts negedges until ready is seen high
    task automatic wait_ready(input int exp_n, input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!o_ready_for_data && n < 40);
        if (!o_ready_for_data) begin
            errors++;
            $display("ready for data never rose (%s) in message %0d", what, msg_no);
        end else begin
            check(n, exp_n, what);
        end
    endtask

    task automatic run_message(input int nblk, input int last_len, input bit stray_start);
        ascon_pkg::block_t key;
        ascon_pkg::block_t nonce;
        int                stall;
        int                n;
        key   = rand_block();
        nonce = rand_block();
        for (int i = 0; i < nblk; i++) begin
            msg_blk[i]  = rand_block();   // bytes past the length stay random
            exp_mask[i] = (i == nblk - 1) ? ~({128{1'b1}} >> (8 * last_len)) : '1;
        end
        exp_tag  = ref_encrypt(key, nonce, nblk, last_len);
        cur_nblk = nblk;
        ct_cnt   = 0;
        tag_cnt  = 0;
        i_key    = key;
        i_nonce  = nonce;
        i_start  = 1'b1;
        @(posedge clk);   // state loads at edge 0
        @(negedge clk);
        i_start = 1'b0;
        wait_ready(12, "ready after start");
        for (int i = 0; i < nblk; i++) begin
            stall = next_rand() % 4;
            if (stray_start && i == 0 && stall == 0) stall = 1;
            for (int k = 0; k < stall; k++) begin
                i_start = stray_start && (i == 0) && (k == 0); // must be ignored
                @(negedge clk);
                i_start = 1'b0;
                check(o_ready_for_data, 1'b1, "ready held during stall");
            end
            i_data        = msg_blk[i];
            i_valid_data  = 1'b1;
            i_last_block  = (i == nblk - 1);
            i_valid_bytes = (i == nblk - 1) ? 5'(last_len) : 5'(next_rand() % 32);
            @(posedge clk);   // accepted here
            @(negedge clk);
            i_valid_data = 1'b0;
            i_last_block = 1'b0;
            i_data       = rand_block();
            if (i != nblk - 1) wait_ready(8, "ready after block");
        end
        n = 0;
        while (tag_cnt == 0 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (tag_cnt == 0) begin
            errors++;
            $display("tag strobe missing in message %0d", msg_no);
        end
        check(ct_cnt, nblk, $sformatf("ciphertext strobe count, message %0d", msg_no));
    endtask

    // outputs are checked on the rising edge after inputs settle at the falling edge
    always @(posedge clk) begin
        if (o_ciphertext_valid) begin
            if (ct_cnt < cur_nblk) begin
                if (exp_mask[ct_cnt] != '0) begin // an empty last block has no ciphertext
                    check(o_ciphertext & exp_mask[ct_cnt],
                          exp_ct[ct_cnt] & exp_mask[ct_cnt],
                          $sformatf("ciphertext, message %0d block %0d", msg_no, ct_cnt));
                end
            end else begin
                errors++;
                $display("unexpected ciphertext strobe at %0t ns in message %0d", $time, msg_no);
            end
            ct_cnt++;
        end
        if (o_tag_valid) begin
            if (tag_cnt == 0) begin
                check(o_tag, exp_tag, $sformatf("tag, message %0d", msg_no));
            end else begin
                errors++;
                $display("extra tag strobe at %0t ns in message %0d", $time, msg_no);
            end
            tag_cnt++;
        end
    end

    initial begin
        int nblk;
        int len;
        clk           = 1'b0;
        i_rst_n       = 1'b0;
        i_start       = 1'b0;
        i_key         = '0;
        i_nonce       = '0;
        i_data        = '0;
        i_valid_data  = 1'b0;
        i_last_block  = 1'b0;
        i_valid_bytes = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        check(o_ready_for_data, 1'b0, "ready after reset");
        check(o_ciphertext_valid, 1'b0, "ciphertext valid after reset");
        check(o_tag_valid, 1'b0, "tag valid after reset");
        run_message(1, 0, 1'b0);   // empty message as a single padding block
        for (int m = 1; m < NUM_MSG; m++) begin
            msg_no = m;
            nblk   = 1 + next_rand() % MAX_BLK;
            len    = next_rand() % 16;
            run_message(nblk, len, (m % 4) == 3);
        end
        repeat (4) @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog budget grows with block and message count
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("%0d checks, %0d errors", checks, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- logic/ascon_top.sv
// ##########################################################################
// Ascon-128a encryptor top, one round per clock, plain ports
// ##########################################################################
`timescale 1ns/1ps

module ascon_top (
    input  logic              clk,
    input  logic              i_rst_n,
    input  logic              i_start,        // pulse, taken in idle only
    input  ascon_pkg::block_t i_key,
    input  ascon_pkg::block_t i_nonce,
    input  ascon_pkg::block_t i_data,
    input  logic              i_valid_data,   // strobe
    input  logic              i_last_block,   // read with i_valid_data
    input  logic [4:0]        i_valid_bytes,  // 0..15 on the last block
    output logic              o_ready_for_data,
    output logic              o_ciphertext_valid,
    output ascon_pkg::block_t o_ciphertext,
    output logic              o_tag_valid,
    output ascon_pkg::block_t o_tag
);

    ascon_ctrl_if u_cif ();

    ascon_ctrl u_ctrl (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_start            (i_start),
        .i_valid_data       (i_valid_data),
        .i_last_block       (i_last_block),
        .o_ready_for_data   (o_ready_for_data),
        .o_ciphertext_valid (o_ciphertext_valid),
        .o_tag_valid        (o_tag_valid),
        .cif                (u_cif.ctrl)
    );

    ascon_state u_state (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_key         (i_key),
        .i_nonce       (i_nonce),
        .i_data        (i_data),
        .i_valid_bytes (i_valid_bytes),
        .o_ciphertext  (o_ciphertext),
        .o_tag         (o_tag),
        .cif           (u_cif.dp)
    );

endmodule

//--- logic/ascon_ctrl.sv
// ##########################################################################
// phase FSM and round counter that drive the datapath steps and the strobes
// ##########################################################################
`timescale 1ns/1ps
`include "ascon_cfg.svh"

module ascon_ctrl (
    input  logic          clk,
    input  logic          i_rst_n,
    input  logic          i_start,
    input  logic          i_valid_data,
    input  logic          i_last_block,
    output logic          o_ready_for_data,
    output logic          o_ciphertext_valid,
    output logic          o_tag_valid,
    ascon_ctrl_if.ctrl    cif
);

    localparam ascon_pkg::round_idx_t PA_LAST = 4'(`ASCON_PA_ROUNDS - 1);
    localparam ascon_pkg::round_idx_t PB_LAST = 4'(`ASCON_PB_ROUNDS - 1);
    // pb rounds reuse the last constants of pa
    localparam ascon_pkg::round_idx_t PB_OFS  = 4'(`ASCON_PA_ROUNDS - `ASCON_PB_ROUNDS);

    ascon_pkg::ctrl_state_e phase;
    ascon_pkg::round_idx_t  round_cnt;
    logic                   last_round;
    logic                   accept;

    // block counts only in WAIT_DATA
    assign accept = (phase == ascon_pkg::WAIT_DATA) && i_valid_data;

    always_comb begin
        if (phase == ascon_pkg::ROUNDS) begin
            last_round = (round_cnt == PB_LAST);
        end else begin
            last_round = (round_cnt == PA_LAST); // init and final both run pa
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase     <= ascon_pkg::IDLE;
            round_cnt <= '0;
        end else begin
            case (phase)
                ascon_pkg::IDLE: begin
                    round_cnt <= '0;
                    if (i_start) phase <= ascon_pkg::INIT; // state loads on this edge
                end
                ascon_pkg::INIT: begin
                    round_cnt <= last_round ? '0 : round_cnt + 4'd1;
                    if (last_round) phase <= ascon_pkg::WAIT_DATA;
                end
                ascon_pkg::WAIT_DATA: begin
                    round_cnt <= '0;
                    if (i_valid_data) begin
                        phase <= i_last_block ? ascon_pkg::FINAL : ascon_pkg::ROUNDS;
                    end
                end
                ascon_pkg::ROUNDS: begin
                    round_cnt <= last_round ? '0 : round_cnt + 4'd1;
                    if (last_round) phase <= ascon_pkg::WAIT_DATA;
                end
                ascon_pkg::FINAL: begin
                    round_cnt <= last_round ? '0 : round_cnt + 4'd1;
                    if (last_round) phase <= ascon_pkg::TAG;
                end
                default: begin
                    round_cnt <= '0;
                    phase     <= ascon_pkg::IDLE; // tag shown for one cycle
                end
            endcase
        end
    end

    // step commands act in the cycle they are high
    assign cif.load_init   = (phase == ascon_pkg::IDLE) && i_start; // start elsewhere ignored
    assign cif.absorb      = accept;
    assign cif.absorb_last = accept && i_last_block;
    assign cif.round_en    = (phase == ascon_pkg::INIT) || (phase == ascon_pkg::ROUNDS) ||
                             (phase == ascon_pkg::FINAL);
    assign cif.round_idx   = (phase == ascon_pkg::ROUNDS) ? round_cnt + PB_OFS : round_cnt;
    assign cif.init_end    = (phase == ascon_pkg::INIT) && last_round;

    assign o_ready_for_data   = (phase == ascon_pkg::WAIT_DATA);
    assign o_ciphertext_valid = accept;           // same cycle as the absorb
    assign o_tag_valid        = (phase == ascon_pkg::TAG);

    // WAIT_DATA is only entered from a round at the last constant index
    a_absorb_phase: assert property (@(posedge clk) disable iff (!i_rst_n)
        cif.absorb |-> $past(o_ready_for_data) ||
                       $past(cif.round_en && (cif.round_idx == PA_LAST)))
        else $error("absorb without a completed init or block round phase");

    a_tag_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_tag_valid |=> !o_tag_valid)
        else $error("tag strobe longer than one cycle");

endmodule

//--- logic/ascon_state.sv
// ##########################################################################
// 320-bit state and key registers, next-state select and tag output
// ##########################################################################
`timescale 1ns/1ps
`include "ascon_cfg.svh"

module ascon_state (
    input  logic              clk,
    input  logic              i_rst_n,
    input  ascon_pkg::block_t i_key,
    input  ascon_pkg::block_t i_nonce,
    input  ascon_pkg::block_t i_data,
    input  logic [4:0]        i_valid_bytes,
    output ascon_pkg::block_t o_ciphertext,
    output ascon_pkg::block_t o_tag,
    ascon_ctrl_if.dp          cif
);

    localparam int W = `ASCON_WORD_W;

    ascon_pkg::state_t x_q;       // x0..x4
    ascon_pkg::block_t key_q;     // held for init end, final and tag
    ascon_pkg::state_t init_s;
    ascon_pkg::state_t absorb_s;
    ascon_pkg::state_t round_s;
    ascon_pkg::state_t round_key_s;

    // iv | key | nonce, big-endian words
    assign init_s[0] = `ASCON_IV;
    assign init_s[1] = i_key[2*W-1:W];
    assign init_s[2] = i_key[W-1:0];
    assign init_s[3] = i_nonce[2*W-1:W];
    assign init_s[4] = i_nonce[W-1:0];

    ascon_round u_round (
        .i_state     (x_q),
        .i_round_idx (cif.round_idx),
        .o_state     (round_s)
    );

    ascon_absorb u_absorb (
        .i_state       (x_q),
        .i_data        (i_data),
        .i_valid_bytes (i_valid_bytes),
        .i_key         (key_q),
        .i_absorb_last (cif.absorb_last),
        .o_state       (absorb_s),
        .o_ciphertext  (o_ciphertext)
    );

    // end of init: key into x3,x4 and the domain bit, empty ad
    always_comb begin
        round_key_s = round_s;
        if (cif.init_end) begin
            round_key_s[3] = round_s[3] ^ key_q[2*W-1:W];
            round_key_s[4] = round_s[4] ^ key_q[W-1:0] ^ {{(W-1){1'b0}}, 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (cif.load_init) begin
            x_q   <= init_s;
            key_q <= i_key;
        end else if (cif.absorb) begin
            x_q <= absorb_s;
        end else if (cif.round_en) begin
            x_q <= round_key_s;
        end
    end

    // valid only with the tag strobe
    assign o_tag = {x_q[3] ^ key_q[2*W-1:W], x_q[4] ^ key_q[W-1:0]};

    a_load_absorb: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(cif.load_init && cif.absorb))
        else $error("load and absorb in the same cycle");

endmodule

//--- logic/ascon_absorb.sv
// ##########################################################################
// block absorb: last-block padding, rate xor, ciphertext, final key addition
// ##########################################################################
`timescale 1ns/1ps
`include "ascon_cfg.svh"

module ascon_absorb (
    input  ascon_pkg::state_t i_state,
    input  ascon_pkg::block_t i_data,
    input  logic [4:0]        i_valid_bytes,
    input  ascon_pkg::block_t i_key,
    input  logic              i_absorb_last,
    output ascon_pkg::state_t o_state,
    output ascon_pkg::block_t o_ciphertext
);

    localparam int W = `ASCON_WORD_W;

    ascon_pkg::block_t blk;      // padded block
    ascon_pkg::block_t key_mask; // key only on the last block

    // byte 0 is the top byte, 0x80 follows the last valid one
    always_comb begin
        blk = i_data;
        if (i_absorb_last) begin
            for (int b = 0; b < `ASCON_RATE_BYTES; b++) begin
                if (5'(b) == i_valid_bytes) begin
                    blk[8*(`ASCON_RATE_BYTES-1-b) +: 8] = 8'h80;
                end else if (5'(b) > i_valid_bytes) begin
                    blk[8*(`ASCON_RATE_BYTES-1-b) +: 8] = 8'h00;
                end
            end
        end
    end

    assign key_mask = i_absorb_last ? i_key : '0;

    assign o_state[0] = i_state[0] ^ blk[2*W-1:W];      // rate lanes
    assign o_state[1] = i_state[1] ^ blk[W-1:0];
    assign o_state[2] = i_state[2] ^ key_mask[2*W-1:W]; // finalization key, 128a rate
    assign o_state[3] = i_state[3] ^ key_mask[W-1:0];
    assign o_state[4] = i_state[4];

    // full block out, the caller keeps the valid bytes
    assign o_ciphertext = {o_state[0], o_state[1]};

    // a full last block would lose its padding byte
    a_last_len: assert final (!i_absorb_last || (i_valid_bytes < 5'd16))
        else $error("last block with %0d valid bytes", i_valid_bytes);

endmodule

//--- logic/ascon_round.sv
// ##########################################################################
// one Ascon permutation round, combinational: constant, sbox, linear layer
// ##########################################################################
`timescale 1ns/1ps

module ascon_round (
    input  ascon_pkg::state_t     i_state,
    input  ascon_pkg::round_idx_t i_round_idx,
    output ascon_pkg::state_t     o_state
);

    localparam int WORD_W = $bits(ascon_pkg::word_t);

    // right rotation pairs of the linear layer
    localparam int ROT_X0_A = 19;
    localparam int ROT_X0_B = 28;
    localparam int ROT_X1_A = 61;
    localparam int ROT_X1_B = 39;
    localparam int ROT_X2_A = 1;
    localparam int ROT_X2_B = 6;
    localparam int ROT_X3_A = 10;
    localparam int ROT_X3_B = 17;
    localparam int ROT_X4_A = 7;
    localparam int ROT_X4_B = 41;

    function automatic ascon_pkg::word_t rotr(input ascon_pkg::word_t x, input int n);
        return (x >> n) | (x << (WORD_W - n));
    endfunction

    logic [7:0] rc;

    assign rc = 8'hf0 - 8'h0f * {4'b0000, i_round_idx}; // f0, e1, d2 ... 4b

    always_comb begin
        ascon_pkg::word_t x0, x1, x2, x3, x4;
        ascon_pkg::word_t t0, t1, t2, t3, t4;
        x0 = i_state[0];
        x1 = i_state[1];
        x2 = i_state[2] ^ {{(WORD_W-8){1'b0}}, rc}; // constant into low byte of x2
        x3 = i_state[3];
        x4 = i_state[4];
        // first affine layer
        x0 = x0 ^ x4;
        x4 = x4 ^ x3;
        x2 = x2 ^ x1;
        // chi on the five lanes, bitsliced
        t0 = ~x0 & x1;
        t1 = ~x1 & x2;
        t2 = ~x2 & x3;
        t3 = ~x3 & x4;
        t4 = ~x4 & x0;
        x0 = x0 ^ t1;
        x1 = x1 ^ t2;
        x2 = x2 ^ t3;
        x3 = x3 ^ t4;
        x4 = x4 ^ t0;
        // second affine layer
        x1 = x1 ^ x0;
        x0 = x0 ^ x4;
        x3 = x3 ^ x2;
        x2 = ~x2;
        // linear diffusion per lane
        o_state[0] = x0 ^ rotr(x0, ROT_X0_A) ^ rotr(x0, ROT_X0_B);
        o_state[1] = x1 ^ rotr(x1, ROT_X1_A) ^ rotr(x1, ROT_X1_B);
        o_state[2] = x2 ^ rotr(x2, ROT_X2_A) ^ rotr(x2, ROT_X2_B);
        o_state[3] = x3 ^ rotr(x3, ROT_X3_A) ^ rotr(x3, ROT_X3_B);
        o_state[4] = x4 ^ rotr(x4, ROT_X4_A) ^ rotr(x4, ROT_X4_B);
    end

endmodule

//--- logic/ascon_ctrl_if.sv
// ##########################################################################
// step commands from the controller to the state datapath
// ##########################################################################
`timescale 1ns/1ps

interface ascon_ctrl_if;

    logic                   load_init;   // load iv, key and nonce
    logic                   absorb;      // take absorbed state
    logic                   absorb_last; // absorb is the padded last block
    logic                   round_en;    // one round this cycle
    ascon_pkg::round_idx_t  round_idx;   // selects round constant
    logic                   init_end;    // last init round, add key and domain bit

    modport ctrl (
        output load_init,
        output absorb,
        output absorb_last,
        output round_en,
        output round_idx,
        output init_end
    );

    modport dp (
        input load_init,
        input absorb,
        input absorb_last,
        input round_en,
        input round_idx,
        input init_end
    );

endinterface

//--- logic/ascon_pkg.sv
// ##########################################################################
// shared types of the Ascon-128a datapath and controller
// ##########################################################################
`include "ascon_cfg.svh"

package ascon_pkg;

    // one lane of the 320-bit state
    typedef logic [`ASCON_WORD_W-1:0] word_t;

    // msb byte is the first byte in message order
    typedef logic [8*`ASCON_RATE_BYTES-1:0] block_t;

    // index 0 is x0, packed so x0 sits in the top bits
    typedef word_t [0:4] state_t;

    // 0..11, constant is f0 - 0f*idx
    typedef logic [3:0] round_idx_t;

    typedef enum logic [2:0] {
        IDLE,      // waiting for start
        INIT,      // 12 rounds after the load
        WAIT_DATA, // ready for a block
        ROUNDS,    // 8 rounds between blocks
        FINAL,     // 12 rounds before the tag
        TAG        // tag strobe, one cycle
    } ctrl_state_e;

endpackage

//--- include/ascon_cfg.svh
// ##########################################################################
// build constants of the Ascon-128a core, included by the RTL and the testbench
// ##########################################################################
`ifndef ASCON_CFG_SVH
`define ASCON_CFG_SVH

// pa, rounds of initialization and finalization
`define ASCON_PA_ROUNDS 12

// pb, rounds between two message blocks
`define ASCON_PB_ROUNDS 8

// 128a rate is two state words
`define ASCON_RATE_BYTES 16

`define ASCON_WORD_W 64

// k=128, r=128, a=12, b=8
`define ASCON_IV 64'h80800c0800000000

`endif
